/* verilog/bp_pkg.sv */
package bp_pkg;

	typedef logic [31:0] addr_t;   // Program counter or target
	typedef logic [6:0]  bp_idx_t; // PC bits 7..1
	typedef logic [23:0] bp_tag_t; // PC bits 31..8
	typedef logic [31:0] count_t;
	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	// Upper bit set means predict taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} bp_state_e;

	localparam int    BP_ENTRIES  = 128;
	localparam int    NUM_STATS   = 5;
	localparam addr_t RESET_PC    = 32'h0000_1000;
	localparam addr_t INSTR_BYTES = 32'd4;

	// Statistics register map
	localparam axil_addr_t REG_PRED_T  = 8'h00;
	localparam axil_addr_t REG_PRED_NT = 8'h04;
	localparam axil_addr_t REG_RES_T   = 8'h08;
	localparam axil_addr_t REG_RES_NT  = 8'h0C;
	localparam axil_addr_t REG_MISPRED = 8'h10;
	localparam axil_addr_t REG_CLEAR   = 8'h14;

	localparam axil_resp_t AXI_OKAY   = 2'b00;
	localparam axil_resp_t AXI_SLVERR = 2'b10;

	typedef struct packed {
		logic  valid;
		logic  taken;
		logic  mispredict;
		addr_t pc;
		addr_t target;     // Actual destination
		addr_t correct_pc; // Refetch address
	} resolve_t;

	typedef struct packed {
		logic  valid; // Lookup happened
		logic  hit;
		logic  taken;
		addr_t next_pc;
	} pred_t;

	typedef struct packed {
		logic       awvalid;
		axil_addr_t awaddr;
		logic       wvalid;
		axil_data_t wdata;
		logic       bready;
		logic       arvalid;
		axil_addr_t araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		axil_resp_t bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

endpackage

/* verilog/branch_predictor.sv */
module branch_predictor (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             lookup_en_i, // Predecoder saw a branch
	input  bp_pkg::addr_t    pc_i,
	input  bp_pkg::resolve_t resolve_i,
	output bp_pkg::pred_t    pred_o
);

	// Table storage
	logic [bp_pkg::BP_ENTRIES-1:0] valid_q;
	bp_pkg::bp_tag_t   tag_q    [bp_pkg::BP_ENTRIES];
	bp_pkg::bp_state_e state_q  [bp_pkg::BP_ENTRIES];
	bp_pkg::addr_t     target_q [bp_pkg::BP_ENTRIES];

	// Lookup side
	bp_pkg::bp_idx_t lk_idx;
	bp_pkg::bp_tag_t lk_tag;
	bp_pkg::addr_t   fall_pc;
	logic            lk_hit;
	logic            lk_taken;

	// Update side
	bp_pkg::bp_idx_t   up_idx;
	bp_pkg::bp_tag_t   up_tag;
	logic              up_match;
	bp_pkg::bp_state_e up_state;

	// One saturating step toward the branch outcome
	function automatic bp_pkg::bp_state_e step_state(
		input bp_pkg::bp_state_e cur,
		input logic              taken
	);
		bp_pkg::bp_state_e nxt;
		nxt = cur;
		case (cur)
			bp_pkg::STRONG_NT: nxt = taken ? bp_pkg::WEAK_NT  : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_NT:   nxt = taken ? bp_pkg::WEAK_T   : bp_pkg::STRONG_NT;
			bp_pkg::WEAK_T:    nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
			bp_pkg::STRONG_T:  nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
			default:           nxt = cur;
		endcase
		return nxt;
	endfunction

	assign lk_idx  = pc_i[7:1]; // Halfword aligned
	assign lk_tag  = pc_i[31:8];
	assign fall_pc = pc_i + bp_pkg::INSTR_BYTES;

	// Zero-cycle lookup, sees contents before this cycle's update
	always_comb begin
		lk_hit   = lookup_en_i && valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
		lk_taken = lk_hit && state_q[lk_idx][1];
	end

	always_comb begin
		pred_o.valid   = lookup_en_i;
		pred_o.hit     = lk_hit;
		pred_o.taken   = lk_taken;
		pred_o.next_pc = lk_taken ? target_q[lk_idx] : fall_pc; // Miss falls through
	end

	assign up_idx   = resolve_i.pc[7:1];
	assign up_tag   = resolve_i.pc[31:8];
	assign up_match = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

	// Train a matching entry, otherwise allocate a fresh one
	always_comb begin
		if (up_match) begin
			up_state = step_state(state_q[up_idx], resolve_i.taken);
		end else begin
			up_state = resolve_i.taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
		end else if (resolve_i.valid) begin
			valid_q[up_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (resolve_i.valid) begin
			tag_q[up_idx]   <= up_tag;
			state_q[up_idx] <= up_state;
			if (resolve_i.taken) begin
				target_q[up_idx] <= resolve_i.target; // Only taken outcomes carry a target
			end
		end
	end

endmodule

/* verilog/pc_generator.sv */
module pc_generator (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             fetch_ready_i, // Back end took the current fetch
	input  bp_pkg::addr_t    next_pc_i,     // Predicted path
	input  bp_pkg::resolve_t resolve_i,
	output bp_pkg::addr_t    fetch_pc_o
);

	bp_pkg::addr_t pc_q;
	bp_pkg::addr_t pc_d;
	logic          redirect;

	assign redirect = resolve_i.mispredict;

	// Redirect wins, even while stalled
	always_comb begin
		if (redirect) begin
			pc_d = resolve_i.correct_pc;
		end else if (fetch_ready_i) begin
			pc_d = next_pc_i;
		end else begin
			pc_d = pc_q; // Hold on stall
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			pc_q <= bp_pkg::RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign fetch_pc_o = pc_q;

endmodule

/* verilog/bp_stats.sv */
module bp_stats (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             fetch_ready_i,
	input  bp_pkg::pred_t    pred_i,
	input  bp_pkg::resolve_t resolve_i,
	input  logic             clear_i, // From the AXI clear register
	output bp_pkg::count_t   pred_taken_o,
	output bp_pkg::count_t   pred_not_taken_o,
	output bp_pkg::count_t   res_taken_o,
	output bp_pkg::count_t   res_not_taken_o,
	output bp_pkg::count_t   mispredict_o
);

	logic [bp_pkg::NUM_STATS-1:0] stat_ev;
	bp_pkg::count_t               cnt_q [bp_pkg::NUM_STATS];
	logic                         pred_issued;

	// Only accepted lookups count as issued predictions
	assign pred_issued = fetch_ready_i && pred_i.valid;

	assign stat_ev[0] = pred_issued && pred_i.taken;
	assign stat_ev[1] = pred_issued && !pred_i.taken;
	assign stat_ev[2] = resolve_i.valid && resolve_i.taken;
	assign stat_ev[3] = resolve_i.valid && !resolve_i.taken;
	assign stat_ev[4] = resolve_i.valid && resolve_i.mispredict;

	// Clear beats increment, counters wrap
	always_ff @(posedge clk_i) begin
		if (!rst_i || clear_i) begin
			for (int i = 0; i < bp_pkg::NUM_STATS; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < bp_pkg::NUM_STATS; i++) begin
				if (stat_ev[i]) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	assign pred_taken_o     = cnt_q[0];
	assign pred_not_taken_o = cnt_q[1];
	assign res_taken_o      = cnt_q[2];
	assign res_not_taken_o  = cnt_q[3];
	assign mispredict_o     = cnt_q[4];

endmodule

/* verilog/bp_stats_axil.sv */
module bp_stats_axil (
	input  logic              clk_i,
	input  logic              rst_i,
	input  bp_pkg::axil_req_t axil_req_i,
	output bp_pkg::axil_rsp_t axil_rsp_o,
	input  bp_pkg::count_t    pred_taken_i,
	input  bp_pkg::count_t    pred_not_taken_i,
	input  bp_pkg::count_t    res_taken_i,
	input  bp_pkg::count_t    res_not_taken_i,
	input  bp_pkg::count_t    mispredict_i,
	output logic              clear_o // One cycle pulse
);

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_e;

	wr_state_e          wr_state_q;
	rd_state_e          rd_state_q;
	logic               wr_accept;
	logic               rd_accept;
	bp_pkg::axil_resp_t bresp_q;
	bp_pkg::axil_resp_t rresp_q;
	bp_pkg::axil_data_t rdata_q;
	bp_pkg::axil_resp_t rd_resp;
	bp_pkg::axil_data_t rd_data;

	// AW and W are taken together, never while a response is pending
	assign wr_accept = (wr_state_q == WR_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
	assign rd_accept = (rd_state_q == RD_IDLE) && axil_req_i.arvalid;
	assign clear_o   = wr_accept && (axil_req_i.awaddr == bp_pkg::REG_CLEAR);

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			wr_state_q <= WR_IDLE;
		end else begin
			case (wr_state_q)
				WR_IDLE: if (wr_accept) wr_state_q <= WR_RESP;
				WR_RESP: if (axil_req_i.bready) wr_state_q <= WR_IDLE;
				default: wr_state_q <= WR_IDLE;
			endcase
		end
	end

	// Only the clear register is writable
	always_ff @(posedge clk_i) begin
		if (wr_accept) begin
			bresp_q <= clear_o ? bp_pkg::AXI_OKAY : bp_pkg::AXI_SLVERR;
		end
	end

	always_comb begin
		rd_resp = bp_pkg::AXI_OKAY;
		case (axil_req_i.araddr)
			bp_pkg::REG_PRED_T:  rd_data = pred_taken_i;
			bp_pkg::REG_PRED_NT: rd_data = pred_not_taken_i;
			bp_pkg::REG_RES_T:   rd_data = res_taken_i;
			bp_pkg::REG_RES_NT:  rd_data = res_not_taken_i;
			bp_pkg::REG_MISPRED: rd_data = mispredict_i;
			bp_pkg::REG_CLEAR:   rd_data = '0; // Reads back as zero
			default: begin
				rd_data = '0;
				rd_resp = bp_pkg::AXI_SLVERR; // Unmapped
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			rd_state_q <= RD_IDLE;
		end else begin
			case (rd_state_q)
				RD_IDLE: if (rd_accept) rd_state_q <= RD_DATA;
				RD_DATA: if (axil_req_i.rready) rd_state_q <= RD_IDLE;
				default: rd_state_q <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_accept) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	always_comb begin
		axil_rsp_o.awready = wr_accept;
		axil_rsp_o.wready  = wr_accept;
		axil_rsp_o.bvalid  = (wr_state_q == WR_RESP);
		axil_rsp_o.bresp   = bresp_q;
		axil_rsp_o.arready = rd_accept;
		axil_rsp_o.rvalid  = (rd_state_q == RD_DATA);
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = rresp_q;
	end

endmodule

/* verilog/fetch_predict_top.sv */
module fetch_predict_top (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              fetch_ready_i,
	input  logic              is_branch_i,   // From the predecoder
	input  bp_pkg::resolve_t  resolve_i,     // From execute
	input  bp_pkg::axil_req_t axil_req_i,
	output bp_pkg::axil_rsp_t axil_rsp_o,
	output bp_pkg::addr_t     fetch_pc_o,
	output bp_pkg::pred_t     prediction_o
);

	bp_pkg::addr_t  fetch_pc;
	bp_pkg::pred_t  pred;
	bp_pkg::count_t cnt_pred_t;
	bp_pkg::count_t cnt_pred_nt;
	bp_pkg::count_t cnt_res_t;
	bp_pkg::count_t cnt_res_nt;
	bp_pkg::count_t cnt_mispred;
	logic           stats_clear;

	assign fetch_pc_o   = fetch_pc;
	assign prediction_o = pred;

	branch_predictor u_predictor (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.lookup_en_i (is_branch_i),
		.pc_i        (fetch_pc),
		.resolve_i   (resolve_i),
		.pred_o      (pred)
	);

	pc_generator u_pc_gen (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.fetch_ready_i (fetch_ready_i),
		.next_pc_i     (pred.next_pc),
		.resolve_i     (resolve_i),
		.fetch_pc_o    (fetch_pc)
	);

	bp_stats u_stats (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.fetch_ready_i    (fetch_ready_i),
		.pred_i           (pred),
		.resolve_i        (resolve_i),
		.clear_i          (stats_clear),
		.pred_taken_o     (cnt_pred_t),
		.pred_not_taken_o (cnt_pred_nt),
		.res_taken_o      (cnt_res_t),
		.res_not_taken_o  (cnt_res_nt),
		.mispredict_o     (cnt_mispred)
	);

	bp_stats_axil u_stats_axil (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.axil_req_i       (axil_req_i),
		.axil_rsp_o       (axil_rsp_o),
		.pred_taken_i     (cnt_pred_t),
		.pred_not_taken_i (cnt_pred_nt),
		.res_taken_i      (cnt_res_t),
		.res_not_taken_i  (cnt_res_nt),
		.mispredict_i     (cnt_mispred),
		.clear_o          (stats_clear)
	);

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 10; // 20 ns period

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

/* testbench/fetch_predict_asserts.sv */
module fetch_predict_asserts (
	input logic              clk_i,
	input logic              rst_i,
	input logic              is_branch_i,
	input bp_pkg::resolve_t  resolve_i,
	input bp_pkg::axil_req_t axil_req_i,
	input bp_pkg::axil_rsp_t axil_rsp_i,
	input bp_pkg::addr_t     fetch_pc_i,
	input bp_pkg::pred_t     pred_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // Assertion failures so far

	// Responses stay up until the master takes them
	a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
		axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
		axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	a_redirect: assert property (@(posedge clk_i) disable iff (!rst_i)
		resolve_i.mispredict |=> fetch_pc_i == $past(resolve_i.correct_pc))
		else begin
			$error("fetch PC missed the redirect");
			fail_count++;
		end

	// A taken prediction needs a hit, anything else falls through
	a_lookup_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
		(pred_i.valid == is_branch_i) &&
		(pred_i.taken ? pred_i.hit : (pred_i.next_pc == fetch_pc_i + 32'd4)))
		else begin
			$error("prediction does not follow the branch flag and fall-through rule");
			fail_count++;
		end

endmodule

bind fetch_predict_top fetch_predict_asserts u_asserts (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.is_branch_i (is_branch_i),
	.resolve_i   (resolve_i),
	.axil_req_i  (axil_req_i),
	.axil_rsp_i  (axil_rsp_o),
	.fetch_pc_i  (fetch_pc_o),
	.pred_i      (prediction_o)
);

/* testbench/fetch_predict_tb.sv */
module fetch_predict_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int            MAX_CYCLES = 4000;
	localparam bp_pkg::addr_t PC_A  = 32'h0000_2010;
	localparam bp_pkg::addr_t PC_B  = 32'h0000_2110; // Same index as PC_A, other tag
	localparam bp_pkg::addr_t TGT_A = 32'h0000_3000;
	localparam bp_pkg::addr_t TGT_B = 32'h0000_3800;

	logic              clk;
	logic              rst;
	logic              fetch_ready;
	logic              is_branch;
	bp_pkg::resolve_t  res;
	bp_pkg::axil_req_t req;
	bp_pkg::axil_rsp_t rsp;
	bp_pkg::addr_t     fetch_pc;
	bp_pkg::pred_t     pred;

	// Reference model
	logic              m_valid  [bp_pkg::BP_ENTRIES];
	bp_pkg::bp_tag_t   m_tag    [bp_pkg::BP_ENTRIES];
	bp_pkg::bp_state_e m_state  [bp_pkg::BP_ENTRIES];
	bp_pkg::addr_t     m_target [bp_pkg::BP_ENTRIES];
	bp_pkg::count_t    m_cnt    [bp_pkg::NUM_STATS]; // Same order as the register map
	bp_pkg::addr_t     m_pc;

	string  test_name;
	int     cycles = 0;
	integer seed = 32'h2b2a;

	tb_clock clock_gen (.clk_o(clk));

	fetch_predict_top UUT (
		.clk_i         (clk),
		.rst_i         (rst),
		.fetch_ready_i (fetch_ready),
		.is_branch_i   (is_branch),
		.resolve_i     (res),
		.axil_req_i    (req),
		.axil_rsp_o    (rsp),
		.fetch_pc_o    (fetch_pc),
		.prediction_o  (pred)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_addr(input bp_pkg::addr_t exp, input bp_pkg::addr_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s: expected %h, actual %h", test_name, exp, act));
	endtask

	task automatic check_pred(input bp_pkg::pred_t exp, input bp_pkg::pred_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s: expected %h, actual %h", test_name, exp, act));
	endtask

	task automatic check_count(input bp_pkg::count_t exp, input bp_pkg::count_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s: expected %0d, actual %0d", test_name, exp, act));
	endtask

	task automatic check_resp(input bp_pkg::axil_resp_t exp, input bp_pkg::axil_resp_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %s: expected %b, actual %b", test_name, exp, act));
	endtask

	function automatic bp_pkg::pred_t model_predict(input bp_pkg::addr_t pc, input logic br);
		bp_pkg::pred_t   p;
		bp_pkg::bp_idx_t i;
		i = pc[7:1];
		p.valid   = br;
		p.hit     = br && m_valid[i] && (m_tag[i] == pc[31:8]);
		p.taken   = p.hit && (m_state[i] inside {bp_pkg::WEAK_T, bp_pkg::STRONG_T});
		p.next_pc = p.taken ? m_target[i] : pc + 32'd4;
		return p;
	endfunction

	function automatic void model_train(input bp_pkg::resolve_t r);
		bp_pkg::bp_idx_t i;
		i = r.pc[7:1];
		if (m_valid[i] && (m_tag[i] == r.pc[31:8])) begin
			if (r.taken && m_state[i] != bp_pkg::STRONG_T)
				m_state[i] = bp_pkg::bp_state_e'(m_state[i] + 2'd1);
			else if (!r.taken && m_state[i] != bp_pkg::STRONG_NT)
				m_state[i] = bp_pkg::bp_state_e'(m_state[i] - 2'd1);
		end else begin
			m_valid[i] = 1'b1; // Allocate
			m_tag[i]   = r.pc[31:8];
			m_state[i] = r.taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
		end
		if (r.taken)
			m_target[i] = r.target;
	endfunction

	// Check this cycle against the model, then step model and DUT
	task automatic tick();
		bp_pkg::pred_t p;
		#1;
		p = model_predict(m_pc, is_branch);
		check_addr(m_pc, fetch_pc);
		check_pred(p, pred);
		if (fetch_ready && is_branch)
			m_cnt[p.taken ? 0 : 1]++;
		if (res.valid) begin
			m_cnt[res.taken ? 2 : 3]++;
			if (res.mispredict)
				m_cnt[4]++;
			model_train(res);
		end
		if (res.mispredict)
			m_pc = res.correct_pc;
		else if (fetch_ready)
			m_pc = p.next_pc;
		@(posedge clk);
		#2;
		res = '0; // Resolves are single-cycle pulses
	endtask

	task automatic resolve_branch(input bp_pkg::addr_t pc, input logic taken,
			input bp_pkg::addr_t target);
		res.valid  = 1'b1;
		res.taken  = taken;
		res.pc     = pc;
		res.target = target;
		tick();
	endtask

	// Redirect fetch to pc, stall there and look it up
	task automatic expect_pred(input bp_pkg::addr_t pc, input logic hit, input logic taken,
			input bp_pkg::addr_t next_pc);
		bp_pkg::pred_t exp;
		is_branch      = 1'b0;
		res.mispredict = 1'b1;
		res.correct_pc = pc;
		tick();
		fetch_ready = 1'b0;
		is_branch   = 1'b1;
		exp.valid   = 1'b1;
		exp.hit     = hit;
		exp.taken   = taken;
		exp.next_pc = next_pc;
		#1;
		check_pred(exp, pred);
		tick();
		is_branch = 1'b0;
	endtask

	task automatic axi_access(input logic write, input bp_pkg::axil_addr_t addr,
			input bp_pkg::axil_data_t wdata, input int delay,
			output bp_pkg::axil_data_t rdata, output bp_pkg::axil_resp_t resp);
		logic accepted;
		req.arvalid = !write;
		req.araddr  = addr;
		req.awvalid = write;
		req.wvalid  = write;
		req.awaddr  = addr;
		req.wdata   = wdata;
		accepted = 1'b0;
		while (!accepted) begin
			#1;
			accepted = write ? (rsp.awready && rsp.wready) : rsp.arready;
			tick();
		end
		req = '0;
		if (write && addr == bp_pkg::REG_CLEAR)
			foreach (m_cnt[k]) m_cnt[k] = '0;
		while (!(rsp.bvalid || rsp.rvalid))
			tick();
		repeat (delay) tick(); // Back-pressure on the response
		req.bready = write;
		req.rready = !write;
		rdata = rsp.rdata;
		resp  = write ? rsp.bresp : rsp.rresp;
		tick();
		req = '0;
	endtask

	task automatic check_counters(input int delay);
		bp_pkg::axil_data_t d;
		bp_pkg::axil_resp_t r;
		is_branch = 1'b0;
		for (int k = 0; k < bp_pkg::NUM_STATS; k++) begin
			axi_access(1'b0, bp_pkg::axil_addr_t'(k << 2), '0, delay, d, r);
			check_resp(bp_pkg::AXI_OKAY, r);
			check_count(m_cnt[k], d);
		end
	endtask

	task automatic test_reset_sequential();
		test_name = "test_reset_sequential";
		check_addr(bp_pkg::RESET_PC, fetch_pc);
		fetch_ready = 1'b1;
		repeat (3) tick();
		check_addr(bp_pkg::RESET_PC + 32'd12, fetch_pc);
		fetch_ready = 1'b0;
		repeat (2) tick();
		check_addr(bp_pkg::RESET_PC + 32'd12, fetch_pc); // Held while stalled
		check_counters(0);
	endtask

	task automatic test_counter_training();
		test_name = "test_counter_training";
		repeat (2) resolve_branch(PC_A, 1'b1, TGT_A);
		expect_pred(PC_A, 1'b1, 1'b1, TGT_A);
		resolve_branch(PC_A, 1'b1, TGT_A);
		resolve_branch(PC_A, 1'b0, TGT_A);
		expect_pred(PC_A, 1'b1, 1'b1, TGT_A); // Down to weakly taken
		resolve_branch(PC_A, 1'b0, TGT_A);
		expect_pred(PC_A, 1'b1, 1'b0, PC_A + 32'd4);
		repeat (4) resolve_branch(PC_A, 1'b0, TGT_A);
		resolve_branch(PC_A, 1'b1, TGT_A);
		expect_pred(PC_A, 1'b1, 1'b0, PC_A + 32'd4); // Saturated low
		repeat (4) resolve_branch(PC_A, 1'b1, TGT_A);
		resolve_branch(PC_A, 1'b0, TGT_A);
		expect_pred(PC_A, 1'b1, 1'b1, TGT_A); // Saturated high
	endtask

	task automatic test_tag_alias();
		test_name = "test_tag_alias";
		repeat (2) resolve_branch(PC_B, 1'b1, TGT_B);
		expect_pred(PC_B, 1'b1, 1'b1, TGT_B);
		expect_pred(PC_A, 1'b0, 1'b0, PC_A + 32'd4);
	endtask

	task automatic test_redirect();
		test_name = "test_redirect";
		fetch_ready    = 1'b0;
		res.mispredict = 1'b1;
		res.correct_pc = 32'h0000_7000;
		tick();
		check_addr(32'h0000_7000, fetch_pc);
		expect_pred(PC_B, 1'b1, 1'b1, TGT_B);
		fetch_ready    = 1'b1;
		is_branch      = 1'b1;
		res.valid      = 1'b1;
		res.mispredict = 1'b1;
		res.pc         = 32'h0000_5004;
		res.correct_pc = 32'h0000_6000;
		#1;
		check_addr(TGT_B, pred.next_pc); // Taken prediction in the same cycle
		tick();
		check_addr(32'h0000_6000, fetch_pc);
		is_branch = 1'b0;
	endtask

	task automatic test_stats_axil();
		bp_pkg::axil_data_t d;
		bp_pkg::axil_resp_t r;
		test_name = "test_stats_axil";
		fetch_ready = 1'b1;
		check_counters(3);
		axi_access(1'b1, bp_pkg::REG_CLEAR, 32'h1, 2, d, r);
		check_resp(bp_pkg::AXI_OKAY, r);
		check_counters(0);
		axi_access(1'b0, 8'h20, '0, 1, d, r);
		check_resp(bp_pkg::AXI_SLVERR, r);
		axi_access(1'b1, bp_pkg::REG_PRED_T, 32'h5, 0, d, r);
		check_resp(bp_pkg::AXI_SLVERR, r);
		axi_access(1'b0, bp_pkg::REG_CLEAR, '0, 0, d, r);
		check_resp(bp_pkg::AXI_OKAY, r);
		check_count('0, d);
	endtask

	task automatic test_random_resolve();
		bp_pkg::addr_t pcs [8];
		logic [31:0]   rnd;
		test_name = "test_random_resolve";
		for (int k = 0; k < 8; k++)
			pcs[k] = 32'h0000_4000 + (k % 4) * 6 + (k / 4) * 32'h100; // Aliasing pairs
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			is_branch      = rnd[0];
			fetch_ready    = rnd[1];
			res.valid      = rnd[2];
			res.taken      = rnd[3];
			res.pc         = pcs[rnd[6:4]];
			res.target     = pcs[rnd[9:7]] + 32'h40;
			res.correct_pc = pcs[rnd[12:10]];
			res.mispredict = !(rnd[13] && rnd[14]); // Mostly redirect back into the set
			tick();
		end
		check_counters(1);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			fail_run("Timeout: the tests did not finish within the cycle limit");
	end

	initial begin
		rst         = 1'b0;
		fetch_ready = 1'b0;
		is_branch   = 1'b0;
		res         = '0;
		req         = '0;
		for (int i = 0; i < bp_pkg::BP_ENTRIES; i++) begin
			m_valid[i]  = 1'b0;
			m_tag[i]    = '0;
			m_state[i]  = bp_pkg::STRONG_NT;
			m_target[i] = '0;
		end
		foreach (m_cnt[k]) m_cnt[k] = '0;
		m_pc = bp_pkg::RESET_PC;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b1;
		test_reset_sequential();
		test_counter_training();
		test_tag_alias();
		test_redirect();
		test_stats_axil();
		test_random_resolve();
		if (UUT.u_asserts.fail_count != 0) begin
			fail_run("A bound assertion failed during the run");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* project.f */
verilog/bp_pkg.sv
verilog/branch_predictor.sv
verilog/pc_generator.sv
verilog/bp_stats.sv
verilog/bp_stats_axil.sv
verilog/fetch_predict_top.sv
testbench/tb_clock.sv
testbench/fetch_predict_asserts.sv
testbench/fetch_predict_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f project.f --top-module fetch_predict_tb
./obj_dir/Vfetch_predict_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression passed" sim.log; then
	exit 0
fi
exit 1
